// ==== Bender.yml ====
package:
  name: gaussian_pyramid

sources:
  - logic/pyr_pixel_pkg.sv
  - logic/pyr_ctrl_pkg.sv
  - logic/pixel_ram.sv
  - logic/blur_engine.sv
  - logic/downsampler.sv
  - logic/pyramid_sequencer.sv
  - logic/buffer_router.sv
  - logic/gaussian_pyramid.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/gaussian_pyramid_chk.sv
      - tests/gaussian_pyramid_tb.sv

// ==== gaussian_pyramid.f ====
+incdir+tests
logic/pyr_pixel_pkg.sv
logic/pyr_ctrl_pkg.sv
logic/pixel_ram.sv
logic/blur_engine.sv
logic/downsampler.sv
logic/pyramid_sequencer.sv
logic/buffer_router.sv
logic/gaussian_pyramid.sv
tests/gaussian_pyramid_chk.sv
tests/gaussian_pyramid_tb.sv

// ==== logic/blur_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module blur_engine #(
    parameter int WIDTH  = 8,
    parameter int HEIGHT = 8
) (
    input  wire                     clk_in,
    input  wire                     rst_in,
    input  wire                     start,
    output pyr_pixel_pkg::mem_rd_t  src_rd,
    input  pyr_pixel_pkg::pixel_t   src_pixel,
    output pyr_pixel_pkg::mem_wr_t  dst_wr,
    output logic                    done
);

    localparam int XW    = $clog2(WIDTH);
    localparam int YW    = $clog2(HEIGHT);
    localparam int ACC_W = pyr_pixel_pkg::BIT_DEPTH + 4;   // sum of weights is 16

    logic          busy;
    logic [3:0]    cnt;       // 0..8 read taps, 9..10 drain and write
    logic [3:0]    tap_d;     // tap of the data now returning
    logic          rd_d;
    logic [XW-1:0] x, nx;
    logic [YW-1:0] y, ny;
    logic [1:0]    col, row;
    logic [ACC_W-1:0] acc, weighted;

    // weights 1 2 1 / 2 4 2 / 1 2 1 as a left shift
    function automatic logic [1:0] tap_shift(input logic [3:0] tap);
        tap_shift = 2'(tap / 4'd3 == 4'd1) + 2'(tap % 4'd3 == 4'd1);
    endfunction

    always_comb begin
        col = 2'(cnt % 4'd3);
        row = 2'(cnt / 4'd3);
        nx  = x;
        ny  = y;
        if (col == 2'd0 && x != '0) nx = x - 1'b1;   // clamp at the left edge
        if (col == 2'd2 && x != XW'(WIDTH - 1)) nx = x + 1'b1;
        if (row == 2'd0 && y != '0) ny = y - 1'b1;
        if (row == 2'd2 && y != YW'(HEIGHT - 1)) ny = y + 1'b1;
    end

    assign src_rd   = '{valid: busy && cnt < 4'd9, addr: pyr_pixel_pkg::addr_t'({ny, nx})};
    assign weighted = ACC_W'(src_pixel) << tap_shift(tap_d);

    always_ff @(posedge clk_in) begin
        tap_d <= cnt;
        if (rd_d) begin
            acc <= (tap_d == 4'd0 ? '0 : acc) + weighted;
        end
        if (cnt == 4'd10) begin
            dst_wr.addr  <= pyr_pixel_pkg::addr_t'({y, x});
            dst_wr.pixel <= acc[ACC_W-1:4];   // divide by 16, truncated
        end
        if (rst_in) begin
            busy         <= 1'b0;
            cnt          <= '0;
            rd_d         <= 1'b0;
            dst_wr.valid <= 1'b0;
            done         <= 1'b0;
        end else begin
            rd_d         <= src_rd.valid;
            dst_wr.valid <= 1'b0;
            done <= dst_wr.valid && dst_wr.addr == pyr_pixel_pkg::addr_t'(WIDTH * HEIGHT - 1);
            if (start && !busy) begin
                busy <= 1'b1;
                cnt  <= '0;
                x    <= '0;
                y    <= '0;
            end else if (busy) begin
                if (cnt == 4'd10) begin
                    dst_wr.valid <= 1'b1;
                    cnt          <= '0;
                    x            <= x + 1'b1;
                    if (x == XW'(WIDTH - 1)) begin
                        y <= y + 1'b1;
                        if (y == YW'(HEIGHT - 1)) busy <= 1'b0;   // last pixel
                    end
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/buffer_router.sv ====
`timescale 1ns/1ns
`default_nettype none

module buffer_router #(
    parameter int WIDTH  = 8,
    parameter int HEIGHT = 8
) (
    input  wire                       clk_in,
    input  pyr_ctrl_pkg::level_t      cur_level,
    input  pyr_ctrl_pkg::op_t         cur_op,
    input  pyr_pixel_pkg::mem_wr_t    load_wr,
    input  pyr_pixel_pkg::mem_rd_t    blur1_rd,
    input  pyr_pixel_pkg::mem_rd_t    blur2_rd,
    input  pyr_pixel_pkg::mem_rd_t    shrink_rd,
    input  pyr_pixel_pkg::mem_wr_t    blur1_wr,
    input  pyr_pixel_pkg::mem_wr_t    blur2_wr,
    input  pyr_pixel_pkg::mem_wr_t    shrink_wr,
    output pyr_pixel_pkg::pixel_t     blur1_pixel,
    output pyr_pixel_pkg::pixel_t     blur2_pixel,
    output pyr_pixel_pkg::pixel_t     shrink_pixel,
    output pyr_ctrl_pkg::level_wr_t   level_write
);

    localparam int N = WIDTH * HEIGHT;

    logic [1:0]             src_sel, dst_sel;   // 0 a1, 1 a2, 2 b1, 3 b2
    pyr_pixel_pkg::mem_rd_t eng_rd;
    pyr_pixel_pkg::mem_wr_t eng_wr;
    pyr_pixel_pkg::mem_rd_t buf_rd  [4];
    pyr_pixel_pkg::mem_wr_t buf_wr  [4];
    pyr_pixel_pkg::pixel_t  buf_pix [4];
    pyr_pixel_pkg::pixel_t  src_pixel;

    always_comb begin
        case (cur_level)   // ping-pong within each octave
            pyr_ctrl_pkg::O1L1: begin src_sel = 2'd0; dst_sel = 2'd0; end
            pyr_ctrl_pkg::O1L2: begin src_sel = 2'd0; dst_sel = 2'd1; end
            pyr_ctrl_pkg::O1L3: begin src_sel = 2'd1; dst_sel = 2'd0; end
            pyr_ctrl_pkg::O2L1: begin src_sel = 2'd0; dst_sel = 2'd2; end
            pyr_ctrl_pkg::O2L2: begin src_sel = 2'd2; dst_sel = 2'd3; end
            default:            begin src_sel = 2'd3; dst_sel = 2'd2; end
        endcase
        case (cur_op)
            pyr_ctrl_pkg::OP_LOAD: begin
                eng_rd = '0;   // load only writes
                eng_wr = load_wr;
            end
            pyr_ctrl_pkg::OP_SHRINK: begin
                eng_rd = shrink_rd;
                eng_wr = shrink_wr;
            end
            default: begin
                eng_rd = dst_sel[1] ? blur2_rd : blur1_rd;   // octave from the target buffer
                eng_wr = dst_sel[1] ? blur2_wr : blur1_wr;
            end
        endcase
        for (int i = 0; i < 4; i++) begin
            buf_rd[i]       = eng_rd;
            buf_rd[i].valid = eng_rd.valid && src_sel == 2'(i);
            buf_wr[i]       = eng_wr;
            buf_wr[i].valid = eng_wr.valid && dst_sel == 2'(i);
        end
    end

    assign src_pixel    = buf_pix[src_sel];
    assign blur1_pixel  = src_pixel;
    assign blur2_pixel  = src_pixel;
    assign shrink_pixel = src_pixel;
    assign level_write  = '{wr: eng_wr, level: cur_level};

    pixel_ram #(.DEPTH(N)) buf_a1 (
        .clk_in(clk_in), .wr(buf_wr[0]), .rd(buf_rd[0]), .rd_pixel(buf_pix[0])
    );
    pixel_ram #(.DEPTH(N)) buf_a2 (
        .clk_in(clk_in), .wr(buf_wr[1]), .rd(buf_rd[1]), .rd_pixel(buf_pix[1])
    );
    pixel_ram #(.DEPTH(N / 4)) buf_b1 (
        .clk_in(clk_in), .wr(buf_wr[2]), .rd(buf_rd[2]), .rd_pixel(buf_pix[2])
    );
    pixel_ram #(.DEPTH(N / 4)) buf_b2 (
        .clk_in(clk_in), .wr(buf_wr[3]), .rd(buf_rd[3]), .rd_pixel(buf_pix[3])
    );

endmodule

`default_nettype wire

// ==== logic/downsampler.sv ====
`timescale 1ns/1ns
`default_nettype none

module downsampler #(
    parameter int OUT_WIDTH  = 4,
    parameter int OUT_HEIGHT = 4
) (
    input  wire                     clk_in,
    input  wire                     rst_in,
    input  wire                     start,
    output pyr_pixel_pkg::mem_rd_t  src_rd,
    input  pyr_pixel_pkg::pixel_t   src_pixel,
    output pyr_pixel_pkg::mem_wr_t  dst_wr,
    output logic                    done
);

    localparam int XW = $clog2(OUT_WIDTH);
    localparam int YW = $clog2(OUT_HEIGHT);

    logic                  busy;
    logic                  rd_d;
    logic [XW-1:0]         x;
    logic [YW-1:0]         y;
    pyr_pixel_pkg::addr_t  out_addr_d;   // output address of the data in flight

    // source row 2y of width 2*OUT_WIDTH, column 2x
    assign src_rd = '{valid: busy, addr: pyr_pixel_pkg::addr_t'({y, 1'b0, x, 1'b0})};

    always_ff @(posedge clk_in) begin
        out_addr_d   <= pyr_pixel_pkg::addr_t'({y, x});
        dst_wr.addr  <= out_addr_d;
        dst_wr.pixel <= src_pixel;
        if (rst_in) begin
            busy         <= 1'b0;
            rd_d         <= 1'b0;
            dst_wr.valid <= 1'b0;
            done         <= 1'b0;
        end else begin
            rd_d         <= busy;
            dst_wr.valid <= rd_d;
            done <= dst_wr.valid
                    && dst_wr.addr == pyr_pixel_pkg::addr_t'(OUT_WIDTH * OUT_HEIGHT - 1);
            if (start && !busy) begin
                busy <= 1'b1;
                x    <= '0;
                y    <= '0;
            end else if (busy) begin
                x <= x + 1'b1;
                if (x == XW'(OUT_WIDTH - 1)) begin
                    y <= y + 1'b1;
                    if (y == YW'(OUT_HEIGHT - 1)) busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/gaussian_pyramid.sv ====
`timescale 1ns/1ns
`default_nettype none

module gaussian_pyramid #(
    parameter int TOP_WIDTH  = 8,   // power of two, 4..64
    parameter int TOP_HEIGHT = 8
) (
    input  wire                       clk_in,
    input  wire                       rst_in,
    input  wire                       start_in,
    output pyr_pixel_pkg::mem_rd_t    ext_read,
    input  pyr_pixel_pkg::pixel_t     ext_pixel,
    output pyr_ctrl_pkg::level_wr_t   level_write,
    output logic                      pyramid_done
);

    pyr_ctrl_pkg::level_t   cur_level;
    pyr_ctrl_pkg::op_t      cur_op;
    pyr_pixel_pkg::mem_wr_t load_wr, blur1_wr, blur2_wr, shrink_wr;
    pyr_pixel_pkg::mem_rd_t blur1_rd, blur2_rd, shrink_rd;
    pyr_pixel_pkg::pixel_t  blur1_pixel, blur2_pixel, shrink_pixel;
    logic blur1_start, blur2_start, shrink_start;
    logic blur1_done, blur2_done, shrink_done;

    pyramid_sequencer #(.WIDTH(TOP_WIDTH), .HEIGHT(TOP_HEIGHT)) sequencer (
        .clk_in(clk_in), .rst_in(rst_in), .start_in(start_in),
        .ext_read(ext_read), .ext_pixel(ext_pixel), .load_wr(load_wr),
        .cur_level(cur_level), .cur_op(cur_op),
        .blur1_start(blur1_start), .blur2_start(blur2_start), .shrink_start(shrink_start),
        .blur1_done(blur1_done), .blur2_done(blur2_done), .shrink_done(shrink_done),
        .pyramid_done(pyramid_done)
    );

    blur_engine #(.WIDTH(TOP_WIDTH), .HEIGHT(TOP_HEIGHT)) blur1 (
        .clk_in(clk_in), .rst_in(rst_in), .start(blur1_start), .src_rd(blur1_rd),
        .src_pixel(blur1_pixel), .dst_wr(blur1_wr), .done(blur1_done)
    );

    // octave 2 works on the half-size frame
    blur_engine #(.WIDTH(TOP_WIDTH / 2), .HEIGHT(TOP_HEIGHT / 2)) blur2 (
        .clk_in(clk_in), .rst_in(rst_in), .start(blur2_start), .src_rd(blur2_rd),
        .src_pixel(blur2_pixel), .dst_wr(blur2_wr), .done(blur2_done)
    );

    downsampler #(.OUT_WIDTH(TOP_WIDTH / 2), .OUT_HEIGHT(TOP_HEIGHT / 2)) shrink (
        .clk_in(clk_in), .rst_in(rst_in), .start(shrink_start), .src_rd(shrink_rd),
        .src_pixel(shrink_pixel), .dst_wr(shrink_wr), .done(shrink_done)
    );

    buffer_router #(.WIDTH(TOP_WIDTH), .HEIGHT(TOP_HEIGHT)) router (
        .clk_in(clk_in), .cur_level(cur_level), .cur_op(cur_op), .load_wr(load_wr),
        .blur1_rd(blur1_rd), .blur2_rd(blur2_rd), .shrink_rd(shrink_rd),
        .blur1_wr(blur1_wr), .blur2_wr(blur2_wr), .shrink_wr(shrink_wr),
        .blur1_pixel(blur1_pixel), .blur2_pixel(blur2_pixel), .shrink_pixel(shrink_pixel),
        .level_write(level_write)
    );

endmodule

`default_nettype wire

// ==== logic/pixel_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_ram #(
    parameter int DEPTH = 64
) (
    input  wire                    clk_in,
    input  pyr_pixel_pkg::mem_wr_t wr,
    input  pyr_pixel_pkg::mem_rd_t rd,
    output pyr_pixel_pkg::pixel_t  rd_pixel
);

    localparam int AW = $clog2(DEPTH);

    pyr_pixel_pkg::pixel_t mem [DEPTH];

    always_ff @(posedge clk_in) begin
        if (wr.valid) begin
            mem[wr.addr[AW-1:0]] <= wr.pixel;
        end
        if (rd.valid) begin
            rd_pixel <= mem[rd.addr[AW-1:0]];   // data one cycle after request
        end
    end

endmodule

`default_nettype wire

// ==== logic/pyr_ctrl_pkg.sv ====
`default_nettype none

package pyr_ctrl_pkg;

    // pyramid levels in the order they are produced
    typedef enum logic [2:0] {O1L1, O1L2, O1L3, O2L1, O2L2, O2L3} level_t;

    // what produces the current level
    typedef enum logic [1:0] {OP_LOAD, OP_BLUR, OP_SHRINK} op_t;

    typedef enum logic [1:0] {S_IDLE, S_LOAD, S_KICK, S_WAIT} seq_state_t;

    // one output pixel tagged with its level
    typedef struct packed {
        pyr_pixel_pkg::mem_wr_t wr;
        level_t                 level;
    } level_wr_t;

endpackage

`default_nettype wire

// ==== logic/pyr_pixel_pkg.sv ====
`default_nettype none

package pyr_pixel_pkg;

    localparam int BIT_DEPTH  = 8;
    localparam int MAX_ADDR_W = 12;   // enough for 64x64 frames

    typedef logic [BIT_DEPTH-1:0]  pixel_t;
    typedef logic [MAX_ADDR_W-1:0] addr_t;

    // read request into a frame buffer
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } mem_rd_t;

    // write request into a frame buffer
    typedef struct packed {
        logic   valid;
        addr_t  addr;
        pixel_t pixel;
    } mem_wr_t;

endpackage

`default_nettype wire

// ==== logic/pyramid_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module pyramid_sequencer #(
    parameter int WIDTH  = 8,
    parameter int HEIGHT = 8
) (
    input  wire                     clk_in,
    input  wire                     rst_in,
    input  wire                     start_in,
    output pyr_pixel_pkg::mem_rd_t  ext_read,
    input  pyr_pixel_pkg::pixel_t   ext_pixel,
    output pyr_pixel_pkg::mem_wr_t  load_wr,
    output pyr_ctrl_pkg::level_t    cur_level,
    output pyr_ctrl_pkg::op_t       cur_op,
    output logic                    blur1_start,
    output logic                    blur2_start,
    output logic                    shrink_start,
    input  wire                     blur1_done,
    input  wire                     blur2_done,
    input  wire                     shrink_done,
    output logic                    pyramid_done
);

    localparam pyr_pixel_pkg::addr_t LAST = pyr_pixel_pkg::addr_t'(WIDTH * HEIGHT - 1);

    pyr_ctrl_pkg::seq_state_t state;
    pyr_ctrl_pkg::level_t     level;
    pyr_pixel_pkg::mem_rd_t   rd_d1, rd_d2;   // follows the two-cycle memory latency
    logic                     kick;
    logic                     eng_done;

    assign cur_level = level;
    assign load_wr   = '{valid: rd_d2.valid, addr: rd_d2.addr, pixel: ext_pixel};
    assign kick      = state == pyr_ctrl_pkg::S_KICK;

    assign blur1_start  = kick && (level == pyr_ctrl_pkg::O1L2 || level == pyr_ctrl_pkg::O1L3);
    assign shrink_start = kick && level == pyr_ctrl_pkg::O2L1;
    assign blur2_start  = kick && (level == pyr_ctrl_pkg::O2L2 || level == pyr_ctrl_pkg::O2L3);
    assign pyramid_done = state == pyr_ctrl_pkg::S_WAIT && level == pyr_ctrl_pkg::O2L3
                          && eng_done;

    always_comb begin
        case (level)
            pyr_ctrl_pkg::O1L1: cur_op = pyr_ctrl_pkg::OP_LOAD;
            pyr_ctrl_pkg::O2L1: cur_op = pyr_ctrl_pkg::OP_SHRINK;
            default:            cur_op = pyr_ctrl_pkg::OP_BLUR;
        endcase
        case (level)
            pyr_ctrl_pkg::O1L2, pyr_ctrl_pkg::O1L3: eng_done = blur1_done;
            pyr_ctrl_pkg::O2L1:                     eng_done = shrink_done;
            default:                                eng_done = blur2_done;
        endcase
    end

    always_ff @(posedge clk_in) begin
        rd_d1.addr <= ext_read.addr;
        rd_d2.addr <= rd_d1.addr;
        if (rst_in) begin
            state          <= pyr_ctrl_pkg::S_IDLE;
            level          <= pyr_ctrl_pkg::O1L1;
            ext_read.valid <= 1'b0;
            rd_d1.valid    <= 1'b0;
            rd_d2.valid    <= 1'b0;
        end else begin
            rd_d1.valid <= ext_read.valid;
            rd_d2.valid <= rd_d1.valid;
            case (state)
                pyr_ctrl_pkg::S_IDLE: begin
                    if (start_in) begin
                        state          <= pyr_ctrl_pkg::S_LOAD;
                        level          <= pyr_ctrl_pkg::O1L1;
                        ext_read.valid <= 1'b1;
                        ext_read.addr  <= '0;
                    end
                end
                pyr_ctrl_pkg::S_LOAD: begin
                    if (ext_read.valid) begin   // one address per cycle
                        if (ext_read.addr == LAST) ext_read.valid <= 1'b0;
                        else ext_read.addr <= ext_read.addr + 1'b1;
                    end
                    if (rd_d2.valid && rd_d2.addr == LAST) begin
                        level <= pyr_ctrl_pkg::O1L2;
                        state <= pyr_ctrl_pkg::S_KICK;
                    end
                end
                pyr_ctrl_pkg::S_KICK: state <= pyr_ctrl_pkg::S_WAIT;
                default: begin
                    if (eng_done) begin
                        if (level == pyr_ctrl_pkg::O2L3) begin
                            state <= pyr_ctrl_pkg::S_IDLE;
                        end else begin
                            level <= pyr_ctrl_pkg::level_t'(level + 3'd1);
                            state <= pyr_ctrl_pkg::S_KICK;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tests/gaussian_pyramid_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module gaussian_pyramid_chk #(
    parameter int N = 64
) (
    input wire                     clk_in,
    input wire                     rst_in,
    input wire                     start_in,
    input pyr_pixel_pkg::mem_rd_t  ext_read,
    input pyr_ctrl_pkg::level_wr_t level_write,
    input wire                     pyramid_done
);

    int   fail_cnt = 0;
    logic quiet;   // high from done until the next start

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            quiet <= 1'b1;
        end else if (start_in) begin
            quiet <= 1'b0;
        end else if (pyramid_done) begin
            quiet <= 1'b1;
        end
    end

    done_single: assert property (@(posedge clk_in) disable iff (rst_in)
        pyramid_done |=> !pyramid_done)
        else begin
            $error("pyramid_done held for more than one cycle");
            fail_cnt++;
        end

    read_range: assert property (@(posedge clk_in) disable iff (rst_in)
        ext_read.valid |-> ext_read.addr < N)
        else begin
            $error("ext_read address %h beyond the frame", ext_read.addr);
            fail_cnt++;
        end

    level_range: assert property (@(posedge clk_in) disable iff (rst_in)
        level_write.wr.valid |-> level_write.wr.addr
            < ((level_write.level < pyr_ctrl_pkg::O2L1) ? N : N / 4))
        else begin
            $error("level write address %h beyond its level", level_write.wr.addr);
            fail_cnt++;
        end

    quiet_after_done: assert property (@(posedge clk_in) disable iff (rst_in)
        quiet |-> !level_write.wr.valid)
        else begin
            $error("level write after pyramid_done and before start");
            fail_cnt++;
        end

endmodule

bind gaussian_pyramid gaussian_pyramid_chk #(.N(TOP_WIDTH * TOP_HEIGHT)) chk0 (
    .clk_in(clk_in), .rst_in(rst_in), .start_in(start_in), .ext_read(ext_read),
    .level_write(level_write), .pyramid_done(pyramid_done)
);

`default_nettype wire

// ==== tests/pyramid_model.svh ====
// capture of the level write stream, one row per level
logic [7:0] got_lvl [6][N];
logic [7:0] exp_lvl [6][N];
int         hit_cnt [6][N];
int         wr_cnt  [6];
int         bad_addr_cnt;
int         last_lvl;
logic       order_bad;

function automatic int level_size(input int lvl);
    return (lvl < 3) ? N : N / 4;   // octave 2 is a quarter of the frame
endfunction

function automatic int clamp_coord(input int v, input int hi);
    if (v < 0) return 0;
    if (v > hi) return hi;
    return v;
endfunction

// 1 2 1 / 2 4 2 / 1 2 1 with edge clamping, sum truncated by 16
function automatic void blur_level(input int src, input int dst, input int w, input int h);
    int sum;
    int sx;
    int sy;
    for (int y = 0; y < h; y++) begin
        for (int x = 0; x < w; x++) begin
            sum = 0;
            for (int dy = -1; dy <= 1; dy++) begin
                for (int dx = -1; dx <= 1; dx++) begin
                    sx  = clamp_coord(x + dx, w - 1);
                    sy  = clamp_coord(y + dy, h - 1);
                    sum += int'(exp_lvl[src][sy * w + sx]) * (dx == 0 ? 2 : 1)
                           * (dy == 0 ? 2 : 1);
                end
            end
            exp_lvl[dst][y * w + x] = 8'(sum >> 4);
        end
    end
endfunction

// keep the pixel at (2x, 2y)
function automatic void shrink_level(input int src, input int dst, input int ow, input int oh);
    for (int y = 0; y < oh; y++) begin
        for (int x = 0; x < ow; x++) begin
            exp_lvl[dst][y * ow + x] = exp_lvl[src][(2 * y) * (2 * ow) + 2 * x];
        end
    end
endfunction

function automatic void build_model();
    for (int a = 0; a < N; a++) begin
        exp_lvl[0][a] = src_img[a];
    end
    blur_level(0, 1, W, H);
    blur_level(1, 2, W, H);
    shrink_level(2, 3, W / 2, H / 2);
    blur_level(3, 4, W / 2, H / 2);
    blur_level(4, 5, W / 2, H / 2);
endfunction

function automatic void clear_capture();
    for (int l = 0; l < 6; l++) begin
        wr_cnt[l] = 0;
        for (int a = 0; a < N; a++) begin
            hit_cnt[l][a] = 0;
            got_lvl[l][a] = 8'h00;
        end
    end
    bad_addr_cnt = 0;
    last_lvl     = 0;
    order_bad    = 1'b0;
    done_cnt     = 0;
endfunction

function automatic void record_write(input int lvl, input int addr, input logic [7:0] pix);
    if (lvl > 5 || addr >= level_size(lvl)) begin
        bad_addr_cnt++;
        return;
    end
    if (lvl < last_lvl) order_bad = 1'b1;   // levels must arrive O1L1 first
    last_lvl = lvl;
    wr_cnt[lvl]++;
    hit_cnt[lvl][addr]++;
    got_lvl[lvl][addr] = pix;
endfunction

// ==== tests/gaussian_pyramid_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module gaussian_pyramid_tb;

    localparam int W = 8;
    localparam int H = 8;
    localparam int N = W * H;
    localparam int RUN_CYCLES = (N + 3) + 2 * (12 * N) + (4 * N / 4) + 2 * (12 * N / 4) + 50;
    localparam int LIMIT = 4 * RUN_CYCLES;   // four pyramid runs

    logic clk_in = 1'b0;
    logic rst_in;
    logic start_in;
    pyr_pixel_pkg::pixel_t   ext_pixel;
    pyr_pixel_pkg::mem_rd_t  ext_read;
    pyr_pixel_pkg::mem_rd_t  req_q = '0;   // request seen one cycle ago
    pyr_ctrl_pkg::level_wr_t level_write;
    logic                    pyramid_done;

    logic [7:0]  src_img [N];
    logic [31:0] lfsr = 32'hd400;
    int cycles, err_cnt, done_cnt, tests_run, tests_failed;

    `include "pyramid_model.svh"

    gaussian_pyramid #(.TOP_WIDTH(W), .TOP_HEIGHT(H)) dut0 (.*);

    always #5 clk_in = ~clk_in;

    // external memory answers two cycles after the request
    always @(posedge clk_in) begin
        req_q     <= ext_read;
        ext_pixel <= #1 req_q.valid ? src_img[int'(req_q.addr) % N] : 8'h00;
    end

    always @(posedge clk_in) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    always @(negedge clk_in) begin
        if (level_write.wr.valid) begin
            record_write(int'(level_write.level), int'(level_write.wr.addr),
                         level_write.wr.pixel);
        end
        if (pyramid_done) done_cnt++;
    end

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);   // galois step
        end
        return b;
    endfunction

    function automatic void fill_random();
        for (int a = 0; a < N; a++) begin
            src_img[a] = random_byte();
        end
        build_model();
    endfunction

    task automatic run_pyramid(input int restart_at);
        clear_capture();
        @(posedge clk_in);
        #1 start_in = 1'b1;
        @(posedge clk_in);
        #1 start_in = 1'b0;
        if (restart_at > 0) begin
            repeat (restart_at) @(posedge clk_in);
            #1 start_in = 1'b1;   // should be ignored while busy
            @(posedge clk_in);
            #1 start_in = 1'b0;
        end
        while (done_cnt == 0) @(negedge clk_in);
        repeat (10) @(negedge clk_in);   // room for a stray second done
    endtask

    task automatic check_run(input string name);
        int size;
        for (int l = 0; l < 6; l++) begin
            size = level_size(l);
            if (wr_cnt[l] != size) begin
                $display("mismatch wr_cnt[%0d]: expected %h got %h", l, size, wr_cnt[l]);
                err_cnt++;
            end
            for (int a = 0; a < size; a++) begin
                if (hit_cnt[l][a] != 1) begin
                    $display("%s: level %0d address %0d written %0d times",
                             name, l, a, hit_cnt[l][a]);
                    err_cnt++;
                end else if (got_lvl[l][a] !== exp_lvl[l][a]) begin
                    $display("mismatch level_write.wr.pixel level %0d addr %h: expected %h got %h",
                             l, a, exp_lvl[l][a], got_lvl[l][a]);
                    err_cnt++;
                end
            end
        end
        if (order_bad) begin
            $display("%s: levels were written out of order", name);
            err_cnt++;
        end
        if (bad_addr_cnt != 0) begin
            $display("%s: %0d writes had an illegal level or address", name, bad_addr_cnt);
            err_cnt++;
        end
        if (done_cnt != 1) begin
            $display("mismatch pyramid_done count: expected %h got %h", 1, done_cnt);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic idle_outputs_low();
        int errs;
        errs = err_cnt;
        repeat (20) begin
            @(negedge clk_in);
            if (ext_read.valid || level_write.wr.valid || pyramid_done) begin
                $display("idle: outputs active without a start (read %b write %b done %b)",
                         ext_read.valid, level_write.wr.valid, pyramid_done);
                err_cnt++;
            end
        end
        finish_test("idle", errs);
    endtask

    task automatic flat_frame();
        int errs;
        errs = err_cnt;
        for (int a = 0; a < N; a++) begin
            src_img[a] = 8'h5a;
            for (int l = 0; l < 6; l++) begin
                exp_lvl[l][a] = 8'h5a;   // the kernel keeps a constant frame
            end
        end
        run_pyramid(0);
        check_run("flat");
        finish_test("flat", errs);
    endtask

    task automatic random_frame();
        int errs;
        errs = err_cnt;
        fill_random();
        run_pyramid(0);
        check_run("random");
        finish_test("random", errs);
    endtask

    task automatic restart_ignored();
        int errs;
        errs = err_cnt;
        fill_random();
        run_pyramid(100);
        check_run("restart");
        fill_random();
        run_pyramid(0);
        check_run("second run");
        finish_test("restart", errs);
    endtask

    initial begin
        rst_in    = 1'b1;
        start_in  = 1'b0;
        ext_pixel = '0;
        repeat (2) @(posedge clk_in);
        #1 rst_in = 1'b0;
        idle_outputs_low();
        flat_frame();
        random_frame();
        restart_ignored();
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_cnt, dut0.chk0.fail_cnt);
        if (err_cnt == 0 && dut0.chk0.fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
